/* include/req_defines.svh */
`ifndef REQ_DEFINES_SVH
`define REQ_DEFINES_SVH

// ring geometry
`define REQ_CHANNELS 4
`define REQ_RING_LOG2 4 // 16 slots, 15 usable

// shared ram holds every ring, channel in the upper bits
`define REQ_RAM_ALOG2 6

// pio register map, in 64-bit words
`define PIO_ADDR_HIGH 2 // length latch
`define PIO_ADDR_RING_BASE 16 // reset at base+2c, push at base+2c+1

`endif

/* hw/pio_pkg.sv */
`include "req_defines.svh"

package pio_pkg;

   // word address on the pio port
   typedef logic [5:0] pio_addr_t;

   // a single host write, one cycle wide, no back-pressure
   typedef struct packed
   {
      pio_addr_t addr;
      logic [63:0] data;
   } pio_write_t;

   // decoded ring actions, one bit per channel
   // at most one bit of either mask is set in a cycle
   typedef struct packed
   {
      logic [`REQ_CHANNELS-1:0] push;  // append descriptor
      logic [`REQ_CHANNELS-1:0] reset; // drop ring contents
   } ring_cmd_t;

endpackage

/* hw/req_pkg.sv */
`include "req_defines.svh"

package req_pkg;

   // lengths and addresses are in 8-byte words
   typedef logic [18:0] desc_count_t;
   typedef logic [60:0] desc_addr_t;

   // one queued transfer, as stored in the shared ram
   typedef struct packed
   {
      desc_count_t count; // upper 19 bits of the ram word
      desc_addr_t addr;
   } desc_entry_t;

   // what goes out to the dma engines
   typedef struct packed
   {
      logic [`REQ_CHANNELS-1:0] valid; // one-hot pulse, or zero
      desc_entry_t entry;              // shared by all channels
   } request_t;

   // index into one ring
   typedef logic [`REQ_RING_LOG2-1:0] ring_ptr_t;

endpackage

/* hw/pio_decoder.sv */
`include "req_defines.svh"

module pio_decoder
(
   input  logic clock,
   input  logic rst_n,
   input  logic pio_wvalid,
   input  pio_pkg::pio_write_t pio_w,
   output pio_pkg::ring_cmd_t cmd,
   output req_pkg::desc_entry_t push_entry
);
   import pio_pkg::*;
   import req_pkg::*;

   desc_count_t pending_count; // length for following pushes
   logic high_write;

   assign high_write = pio_wvalid && (pio_w.addr == pio_addr_t'(`PIO_ADDR_HIGH));

   // length latch, held until the host rewrites it
   always_ff @(posedge clock)
   begin
      if (!rst_n)
         pending_count <= '0;
      else if (high_write)
         pending_count <= pio_w.data[21:3]; // bytes to words
   end

   // ring register decode
   always_comb
   begin
      cmd = '0;
      for (int i = 0; i < `REQ_CHANNELS; i++)
      begin
         // reset needs bit 0, so a zero write is harmless
         cmd.reset[i] = pio_wvalid && pio_w.data[0] &&
                        (pio_w.addr == pio_addr_t'(`PIO_ADDR_RING_BASE + 2 * i));
         cmd.push[i] = pio_wvalid &&
                       (pio_w.addr == pio_addr_t'(`PIO_ADDR_RING_BASE + 2 * i + 1));
      end
   end

   // entry valid only alongside a push bit
   assign push_entry.count = pending_count;
   assign push_entry.addr = pio_w.data[63:3]; // word address
endmodule

/* hw/desc_ram.sv */
module desc_ram
#(
   parameter type entry_t = logic [79:0],
   parameter int depth_log2 = 6
)
(
   input  logic clock,
   input  logic we,
   input  logic [depth_log2-1:0] waddr,
   input  entry_t wdata,
   input  logic [depth_log2-1:0] raddr,
   output entry_t rdata
);

   entry_t mem [2**depth_log2]; // contents undefined until written

   // one write port, one read port, same clock
   always_ff @(posedge clock)
   begin
      if (we)
         mem[waddr] <= wdata;
      rdata <= mem[raddr]; // read-before-write on collision
   end
endmodule

/* hw/ring_pointers.sv */
`include "req_defines.svh"

module ring_pointers
(
   input  logic clock,
   input  logic rst_n,
   input  pio_pkg::ring_cmd_t cmd,
   input  logic pop,
   input  logic [$clog2(`REQ_CHANNELS)-1:0] pop_channel,
   output logic [`REQ_CHANNELS-1:0] nonempty,
   output req_pkg::ring_ptr_t [`REQ_CHANNELS-1:0] pop_ptr,
   output logic ram_we,
   output logic [`REQ_RAM_ALOG2-1:0] ram_waddr
);
   import req_pkg::*;

   localparam int chan_bits = $clog2(`REQ_CHANNELS);

   ring_ptr_t [`REQ_CHANNELS-1:0] push_ptr;
   ring_ptr_t [`REQ_CHANNELS-1:0] used;   // entries held per ring
   logic [`REQ_CHANNELS-1:0] full;
   logic [`REQ_CHANNELS-1:0] has_data;
   logic [`REQ_CHANNELS-1:0] accept;      // pushes that reach the ram
   logic [chan_bits-1:0] push_channel;

   always_comb
   begin
      push_channel = '0;
      for (int i = 0; i < `REQ_CHANNELS; i++)
      begin
         used[i] = push_ptr[i] - pop_ptr[i]; // wraps, one slot kept free
         full[i] = &used[i];
         has_data[i] = |used[i];
         if (cmd.push[i])
            push_channel = chan_bits'(i);
      end
   end

   assign accept = cmd.push & ~full; // push to a full ring is lost
   assign ram_we = |accept;
   assign ram_waddr = {push_channel, push_ptr[push_channel]};

   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         push_ptr <= '0;
         pop_ptr <= '0;
         nonempty <= '0;
      end
      else
      begin
         for (int i = 0; i < `REQ_CHANNELS; i++)
         begin
            if (cmd.reset[i])
            begin
               push_ptr[i] <= '0; // reset wins over push and pop
               pop_ptr[i] <= '0;
            end
            else
            begin
               if (accept[i])
                  push_ptr[i] <= push_ptr[i] + 1'b1;
               if (pop && (pop_channel == chan_bits'(i)))
                  pop_ptr[i] <= pop_ptr[i] + 1'b1;
            end
         end
         // registered flag lags the pointers by a cycle
         // stale only between slots of the same channel
         nonempty <= has_data & ~cmd.reset;
      end
   end
endmodule

/* hw/request_ctrl.sv */
`include "req_defines.svh"

module request_ctrl
(
   input  logic clock,
   input  logic rst_n,
   input  logic [`REQ_CHANNELS-1:0] req_ready,
   input  logic [`REQ_CHANNELS-1:0] nonempty,
   input  req_pkg::ring_ptr_t [`REQ_CHANNELS-1:0] pop_ptr,
   output logic pop,
   output logic [$clog2(`REQ_CHANNELS)-1:0] pop_channel,
   output logic [`REQ_RAM_ALOG2-1:0] ram_raddr,
   input  req_pkg::desc_entry_t ram_rdata,
   output req_pkg::request_t req
);
   import req_pkg::*;

   localparam int chan_bits = $clog2(`REQ_CHANNELS);

   logic [chan_bits-1:0] slot;                // round-robin owner of this cycle
   logic [`REQ_CHANNELS-1:0] issue;           // one-hot of the popped channel
   logic [2:0][`REQ_CHANNELS-1:0] valid_q;    // addr reg, ram read, output reg
   desc_entry_t entry_q;

   // free-running slot, each channel gets every fourth cycle
   always_ff @(posedge clock)
   begin
      if (!rst_n)
         slot <= '0;
      else
         slot <= slot + 1'b1;
   end

   // ready only counts in the channel's own slot
   assign pop = nonempty[slot] && req_ready[slot];
   assign pop_channel = slot;
   assign issue = {{(`REQ_CHANNELS - 1){1'b0}}, pop} << slot;

   // read address follows the slot every cycle, used only on a pop
   always_ff @(posedge clock)
   begin
      ram_raddr <= {slot, pop_ptr[slot]};
   end

   // valid rides alongside the ram read
   always_ff @(posedge clock)
   begin
      if (!rst_n)
         valid_q <= '0;
      else
         valid_q <= {valid_q[1:0], issue};
   end

   // last stage, lines up with valid_q[2]
   always_ff @(posedge clock)
   begin
      entry_q <= ram_rdata;
   end

   assign req.valid = valid_q[2]; // pop cycle plus 3
   assign req.entry = entry_q;    // meaningful only with a valid bit
endmodule

/* hw/request_top.sv */
`include "req_defines.svh"

module request_top
(
   input  logic clock,
   input  logic rst_n,
   input  logic pio_wvalid,
   input  pio_pkg::pio_write_t pio_w,
   input  logic [`REQ_CHANNELS-1:0] req_ready,
   output req_pkg::request_t req
);
   import pio_pkg::*;
   import req_pkg::*;

   ring_cmd_t cmd;
   desc_entry_t push_entry; // write data for the ram
   desc_entry_t ram_rdata;
   ring_ptr_t [`REQ_CHANNELS-1:0] pop_ptr;
   logic [`REQ_CHANNELS-1:0] nonempty;
   logic pop;
   logic [$clog2(`REQ_CHANNELS)-1:0] pop_channel;
   logic ram_we;
   logic [`REQ_RAM_ALOG2-1:0] ram_waddr;
   logic [`REQ_RAM_ALOG2-1:0] ram_raddr;

   // host side
   pio_decoder u_pio_decoder
   (
      .clock      (clock),
      .rst_n      (rst_n),
      .pio_wvalid (pio_wvalid),
      .pio_w      (pio_w),
      .cmd        (cmd),
      .push_entry (push_entry)
   );

   ring_pointers u_ring_pointers
   (
      .clock       (clock),
      .rst_n       (rst_n),
      .cmd         (cmd),
      .pop         (pop),
      .pop_channel (pop_channel),
      .nonempty    (nonempty),
      .pop_ptr     (pop_ptr),
      .ram_we      (ram_we),
      .ram_waddr   (ram_waddr)
   );

   // every ring in one block ram
   desc_ram #(.entry_t(desc_entry_t), .depth_log2(`REQ_RAM_ALOG2)) u_desc_ram
   (
      .clock (clock),
      .we    (ram_we),
      .waddr (ram_waddr),
      .wdata (push_entry),
      .raddr (ram_raddr),
      .rdata (ram_rdata)
   );

   // engine side
   request_ctrl u_request_ctrl
   (
      .clock       (clock),
      .rst_n       (rst_n),
      .req_ready   (req_ready),
      .nonempty    (nonempty),
      .pop_ptr     (pop_ptr),
      .pop         (pop),
      .pop_channel (pop_channel),
      .ram_raddr   (ram_raddr),
      .ram_rdata   (ram_rdata),
      .req         (req)
   );
endmodule

/* tests/request_props.sv */
`include "req_defines.svh"

module request_props
(
   input  logic clock,
   input  logic rst_n,
   input  logic [`REQ_CHANNELS-1:0] req_ready,
   input  logic [`REQ_CHANNELS-1:0] nonempty,
   input  logic pop,
   input  logic [$clog2(`REQ_CHANNELS)-1:0] pop_channel,
   input  req_pkg::request_t req
);

   logic [`REQ_CHANNELS-1:0] pop_mask; // one-hot of the popping channel
   logic onehot_bad = 1'b0;
   logic latency_bad = 1'b0;
   logic pop_bad = 1'b0;
   logic failed;                       // sticky, any property broken

   assign pop_mask = pop ? (`REQ_CHANNELS'(1) << pop_channel) : '0;
   assign failed = onehot_bad | latency_bad | pop_bad;

   // at most one engine sees a request per cycle
   valid_onehot: assert property (@(posedge clock) disable iff (!rst_n)
      $onehot0(req.valid))
   else
   begin
      $error("request valid mask is not one-hot");
      onehot_bad = 1'b1;
   end

   // addr reg, ram read, output reg
   valid_latency: assert property (@(posedge clock) disable iff (!rst_n)
      req.valid == $past(pop_mask, 3))
   else
   begin
      $error("request valid does not trail its pop by 3 cycles");
      latency_bad = 1'b1;
   end

   // pop only from a ring with data and a ready engine
   pop_allowed: assert property (@(posedge clock) disable iff (!rst_n)
      pop |-> (nonempty[pop_channel] && req_ready[pop_channel]))
   else
   begin
      $error("pop without nonempty ring and ready engine");
      pop_bad = 1'b1;
   end
endmodule

bind request_ctrl request_props ctrl_props
(
   .clock       (clock),
   .rst_n       (rst_n),
   .req_ready   (req_ready),
   .nonempty    (nonempty),
   .pop         (pop),
   .pop_channel (pop_channel),
   .req         (req)
);

/* tests/request_tb.sv */
`include "req_defines.svh"

module request_tb;
   import pio_pkg::*;
   import req_pkg::*;

   localparam int ring_limit = (1 << `REQ_RING_LOG2) - 1; // one slot kept free
   localparam int wait_limit = 400;                        // cycles per wait loop

   logic clock = 1'b0;
   logic rst_n;
   logic pio_wvalid;
   pio_write_t pio_w;
   logic [`REQ_CHANNELS-1:0] req_ready;
   request_t req;

   logic [31:0] lfsr_state = 32'd24;
   desc_count_t latched_count;                  // model of the length latch
   desc_entry_t expected [`REQ_CHANNELS][256];  // per channel, in push order
   int head [`REQ_CHANNELS];
   int tail [`REQ_CHANNELS];
   int received [`REQ_CHANNELS];

   request_top DUT
   (
      .clock      (clock),
      .rst_n      (rst_n),
      .pio_wvalid (pio_wvalid),
      .pio_w      (pio_w),
      .req_ready  (req_ready),
      .req        (req)
   );

   always #10 clock = ~clock;

   // galois form, one step per bit
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 32'hA3000000;
      return out;
   endfunction

   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
         r = {r[62:0], lfsr_bit()};
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [79:0] got,
                              input logic [79:0] want);
      if (got !== want)
      begin
         $display("ERR %s got %h expected %h", name, got, want);
         abort_run("value mismatch, stopping");
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clock);
   endtask

   // no valid bit inside mask for n cycles
   task automatic expect_quiet(input logic [`REQ_CHANNELS-1:0] mask, input int n);
      repeat (n)
      begin
         @(negedge clock);
         check_value("req.valid", req.valid & mask, '0);
      end
   endtask

   task automatic set_ready(input logic [`REQ_CHANNELS-1:0] mask);
      @(posedge clock);
      #2;
      req_ready = mask;
   endtask

   // one strobe, then an idle cycle
   task automatic pio_write(input logic [5:0] addr, input logic [63:0] data);
      @(posedge clock);
      #2;
      pio_wvalid = 1'b1;
      pio_w.addr = addr;
      pio_w.data = data;
      @(posedge clock);
      #2;
      pio_wvalid = 1'b0;
   endtask

   task automatic set_length(input desc_count_t count);
      logic [63:0] data;
      data = random_bits(64); // junk outside the count field
      data[21:3] = count;
      pio_write(6'(`PIO_ADDR_HIGH), data);
      latched_count = count;
   endtask

   // model drops pushes to a full ring, valid only while nothing pops
   task automatic push_desc(input int ch);
      desc_addr_t addr;
      logic [2:0] low;
      addr = desc_addr_t'(random_bits(61));
      low = 3'(random_bits(3));
      pio_write(6'(`PIO_ADDR_RING_BASE + 2 * ch + 1), {addr, low});
      if (tail[ch] - head[ch] < ring_limit)
      begin
         expected[ch][tail[ch] % 256] = {latched_count, addr};
         tail[ch]++;
      end
   endtask

   task automatic reset_ring(input int ch);
      pio_write(6'(`PIO_ADDR_RING_BASE + 2 * ch), 64'd1);
      head[ch] = tail[ch]; // queued entries are gone
   endtask

   task automatic wait_drained(input logic [`REQ_CHANNELS-1:0] mask);
      int cycles;
      logic busy;
      cycles = 0;
      busy = 1'b1;
      while (busy)
      begin
         busy = 1'b0;
         for (int c = 0; c < `REQ_CHANNELS; c++)
            if (mask[c] && head[c] != tail[c])
               busy = 1'b1;
         if (busy && cycles == wait_limit)
            abort_run("timeout waiting for queued descriptors to come out");
         else if (busy)
         begin
            cycles++;
            @(posedge clock);
         end
      end
   endtask

   // scoreboard, sampled away from the active edge
   always @(negedge clock)
   begin : monitor
      int ch;
      desc_entry_t want;
      if (rst_n === 1'b1 && req.valid !== '0)
      begin
         if (!$onehot(req.valid))
            abort_run($sformatf("valid mask %h has more than one bit set", req.valid));
         else
         begin
            ch = $clog2(req.valid); // one-hot to index
            if (head[ch] == tail[ch])
               abort_run($sformatf("request on channel %0d with nothing queued", ch));
            else
            begin
               want = expected[ch][head[ch] % 256];
               check_value("req.entry.addr", req.entry.addr, want.addr);
               check_value("req.entry.count", req.entry.count, want.count);
               head[ch]++;
               received[ch]++;
            end
         end
      end
   end

   task automatic test_reset_state();
      set_ready('1);
      expect_quiet('1, 20);
   endtask

   task automatic test_single_channel();
      set_ready('0);
      repeat (5) push_desc(1);
      set_ready(4'b0010);
      wait_drained(4'b0010);
      expect_quiet('1, 8); // nothing beyond the five
   endtask

   task automatic test_length_latch();
      desc_count_t first;
      set_ready('0);
      first = desc_count_t'(random_bits(19));
      set_length(first);
      push_desc(0);
      push_desc(0);
      set_length(~first); // only the next push sees this
      push_desc(0);
      set_ready(4'b0001);
      wait_drained(4'b0001);
      expect_quiet('1, 8);
   endtask

   task automatic test_round_robin();
      int base2;
      set_ready('0);
      base2 = received[2];
      set_length(desc_count_t'(random_bits(19)));
      for (int k = 0; k < 3; k++)
         for (int c = 0; c < `REQ_CHANNELS; c++)
            push_desc(c);
      set_ready(4'b1011); // engine 2 stalled
      wait_drained(4'b1011);
      idle(20);
      check_value("channel 2 requests", received[2] - base2, 0);
      check_value("channel 2 queued", tail[2] - head[2], 3);
      set_ready('1);
      wait_drained('1);
   endtask

   task automatic test_full_and_reset();
      set_ready('0);
      repeat (18) push_desc(3); // last 3 hit a full ring
      set_ready(4'b1000);
      wait_drained(4'b1000);
      expect_quiet('1, 8); // only the first 15 made it
      set_ready('0);
      repeat (4) push_desc(3);
      reset_ring(3);
      set_ready(4'b1000);
      expect_quiet(4'b1000, 20); // reset ring stays silent
      repeat (3) push_desc(3); // ring usable again
      wait_drained(4'b1000);
      expect_quiet('1, 8);
   endtask

   initial
   begin
      rst_n = 1'b0;
      pio_wvalid = 1'b0;
      pio_w = '0;
      req_ready = '0;
      latched_count = '0;
      for (int c = 0; c < `REQ_CHANNELS; c++)
      begin
         head[c] = 0;
         tail[c] = 0;
         received[c] = 0;
      end
      repeat (10) @(posedge clock);
      #2;
      rst_n = 1'b1;
      test_reset_state();
      test_single_channel();
      test_length_latch();
      test_round_robin();
      test_full_and_reset();
      idle(5);
      if (!DUT.u_request_ctrl.ctrl_props.failed)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
         abort_run("a property bound on request_ctrl failed");
   end
endmodule

/* list.f */
+incdir+include
hw/pio_pkg.sv
hw/req_pkg.sv
hw/pio_decoder.sv
hw/desc_ram.sv
hw/ring_pointers.sv
hw/request_ctrl.sv
hw/request_top.sv
tests/request_props.sv
tests/request_tb.sv

/* Bender.yml */
package:
  name: request_queue

sources:
  - include_dirs:
      - include
    files:
      - hw/pio_pkg.sv
      - hw/req_pkg.sv
      - hw/pio_decoder.sv
      - hw/desc_ram.sv
      - hw/ring_pointers.sv
      - hw/request_ctrl.sv
      - hw/request_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/request_props.sv
      - tests/request_tb.sv
